// ==== dv/rv_exec_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_sva (
    input wire                         clk,
    input wire                         rst_n,
    input wire rv_exec_pkg::op_stage_t op,
    input wire rv_exec_pkg::retire_t   retire
);

    // x0 reads zero through the register file and the bypass
    x0_rs1_zero: assert property (@(posedge clk) disable iff (!rst_n)
        op.valid && op.inst[19:15] == '0 |-> op.rs1_val == '0)
        else $error("x0 read as nonzero on rs1");

    x0_rs2_zero: assert property (@(posedge clk) disable iff (!rst_n)
        op.valid && op.inst[24:20] == '0 |-> op.rs2_val == '0)
        else $error("x0 read as nonzero on rs2");

    // Any exception goes to the trap vector without a register write
    trap_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.exc != rv_exec_pkg::EXC_NONE |->
            retire.next_pc == rv_exec_pkg::TRAP_VECTOR && !retire.rd_we)
        else $error("trapping instruction did not redirect to the trap vector");

endmodule

bind execute_stage rv_exec_sva i_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .op     (op),
    .retire (retire)
);

`default_nettype wire

// ==== dv/tb_rv_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_CYCLES = 4000;
    // Reset, pipeline drain and slack
    localparam int          TIMEOUT_NS = (NUM_CYCLES + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED       = 32'h5831_7ed7;

    typedef struct packed {
        logic                 check_data;
        rv_exec_pkg::retire_t r;
    } exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_valid;
    rv_exec_pkg::inst_t   inst;
    rv_exec_pkg::xlen_t   pc;
    rv_exec_pkg::retire_t retire;

    logic [31:0] model_regs [32];
    logic [31:0] model_mepc;
    exp_t        exp_q [$];
    int          errors;
    int          checks;

    rv_exec_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] alu_result(input logic [31:0] a, input logic [31:0] b,
                                               input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_result = alt ? a - b : a + b;
            3'b001:  alu_result = a << b[4:0];
            3'b010:  alu_result = {31'b0, $signed(a) < $signed(b)};
            3'b011:  alu_result = {31'b0, a < b};
            3'b100:  alu_result = a ^ b;
            3'b101: begin
                if (alt) alu_result = $unsigned($signed(a) >>> b[4:0]);
                else     alu_result = a >> b[4:0];
            end
            3'b110:  alu_result = a | b;
            default: alu_result = a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] f3);
        case (f3)
            3'b000:  branch_taken = a == b;
            3'b001:  branch_taken = a != b;
            3'b100:  branch_taken = $signed(a) < $signed(b);
            3'b101:  branch_taken = $signed(a) >= $signed(b);
            3'b110:  branch_taken = a < b;
            3'b111:  branch_taken = a >= b;
            default: branch_taken = 1'b0;
        endcase
    endfunction

    // Weighted opcode mix, registers limited to x0..x7
    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        int unsigned sel;
        logic        alt;
        w = $urandom;
        sel = $urandom_range(0, 99);
        w[11:10] = 2'b00;
        w[19:18] = 2'b00;
        if (sel < 15) begin
            w[6:0] = rv_exec_pkg::OP;
            w[24:23] = 2'b00;
            alt = w[31] && (w[14:12] == 3'b000 || w[14:12] == 3'b101);
            w[31:25] = alt ? 7'h20 : 7'h00;
        end else if (sel < 30) begin
            w[6:0] = rv_exec_pkg::OP_IMM;
            if (w[14:12] == 3'b001) w[31:25] = 7'h00;
            if (w[14:12] == 3'b101) w[31:25] = {1'b0, w[30], 5'b0};
        end else if (sel < 35) begin
            w[6:0] = rv_exec_pkg::LUI;
        end else if (sel < 40) begin
            w[6:0] = rv_exec_pkg::AUIPC;
        end else if (sel < 47) begin
            w[6:0] = rv_exec_pkg::JAL;
        end else if (sel < 54) begin
            w[6:0] = rv_exec_pkg::JALR;
            w[14:12] = 3'b000;
        end else if (sel < 66) begin
            w[6:0] = rv_exec_pkg::BRANCH;
            w[24:23] = 2'b00;
            if (!w[14]) w[13] = 1'b0;
            if ($urandom_range(0, 3) == 0) w[24:20] = w[19:15];
        end else if (sel < 76) begin
            w[6:0] = rv_exec_pkg::LOAD;
            if (w[14]) w[13] = 1'b0;
            if (w[13:12] == 2'b11) w[12] = 1'b0;
            if ($urandom_range(0, 1) == 0) begin
                w[19:15] = 5'd0;
                w[21:20] = 2'b00;
            end
        end else if (sel < 86) begin
            w[6:0] = rv_exec_pkg::STORE;
            w[24:23] = 2'b00;
            w[14] = 1'b0;
            if (w[13:12] == 2'b11) w[12] = 1'b0;
            if ($urandom_range(0, 1) == 0) begin
                w[19:15] = 5'd0;
                w[8:7] = 2'b00;
            end
        end else if (sel < 88) begin
            w[6:0] = rv_exec_pkg::FENCE;
        end else if (sel < 96) begin
            w[6:0] = rv_exec_pkg::SYSTEM;
            w[14:12] = 3'b000;
            case ($urandom_range(0, 4))
                0:       w[31:20] = rv_exec_pkg::ECALL;
                1:       w[31:20] = rv_exec_pkg::EBREAK;
                2:       w[31:20] = rv_exec_pkg::MRET;
                3:       w[31:20] = 12'h105;
                default: w[14:12] = w[31] ? 3'b010 : 3'b101;
            endcase
        end else begin
            w[6:0] = w[31] ? 7'h7f : 7'h0b;
        end
        return w;
    endfunction

    // ISA reference for one instruction, updates model state
    function automatic exp_t model_exec(input logic [31:0] w, input logic [31:0] p);
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm_i;
        logic [31:0]       imm_s;
        logic [31:0]       imm_b;
        logic [31:0]       imm_u;
        logic [31:0]       imm_j;
        logic [31:0]       res;
        logic [31:0]       nxt;
        logic [31:0]       tgt;
        logic [2:0]        f3;
        logic              wr;
        logic              mem;
        rv_exec_pkg::exc_t exc;
        exp_t              e;
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        f3 = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        nxt = p + 32'd4;
        res = '0;
        wr = 1'b0;
        mem = 1'b0;
        exc = rv_exec_pkg::EXC_NONE;
        case (w[6:0])
            rv_exec_pkg::LUI: begin
                res = imm_u;
                wr = 1'b1;
            end
            rv_exec_pkg::AUIPC: begin
                res = p + imm_u;
                wr = 1'b1;
            end
            rv_exec_pkg::OP: begin
                res = alu_result(a, b, f3, w[30]);
                wr = 1'b1;
            end
            rv_exec_pkg::OP_IMM: begin
                res = alu_result(a, imm_i, f3, f3 == 3'b101 && w[30]);
                wr = 1'b1;
            end
            rv_exec_pkg::JAL, rv_exec_pkg::JALR: begin
                res = p + 32'd4;
                wr = 1'b1;
                tgt = (w[6:0] == rv_exec_pkg::JAL) ? p + imm_j : a + imm_i;
                tgt[0] = 1'b0;
                if (tgt[1:0] != 2'b00) exc = rv_exec_pkg::EXC_INST_MISALIGN;
                else                   nxt = tgt;
            end
            rv_exec_pkg::BRANCH: begin
                tgt = p + imm_b;
                if (branch_taken(a, b, f3)) begin
                    if (tgt[1:0] != 2'b00) exc = rv_exec_pkg::EXC_INST_MISALIGN;
                    else                   nxt = tgt;
                end
            end
            rv_exec_pkg::LOAD, rv_exec_pkg::STORE: begin
                mem = 1'b1;
                res = a + ((w[6:0] == rv_exec_pkg::LOAD) ? imm_i : imm_s);
                if ((w[13:12] == rv_exec_pkg::WORD && res[1:0] != 2'b00) ||
                    (w[13:12] == rv_exec_pkg::HALF && res[0])) begin
                    exc = (w[6:0] == rv_exec_pkg::LOAD) ? rv_exec_pkg::EXC_LOAD_MISALIGN :
                                                          rv_exec_pkg::EXC_STORE_MISALIGN;
                end
            end
            rv_exec_pkg::FENCE: ;
            rv_exec_pkg::SYSTEM: begin
                if (f3 != 3'b000) begin
                    wr = 1'b1;
                end else if (w[31:20] == rv_exec_pkg::ECALL) begin
                    exc = rv_exec_pkg::EXC_ECALL;
                end else if (w[31:20] == rv_exec_pkg::EBREAK) begin
                    exc = rv_exec_pkg::EXC_EBREAK;
                end else if (w[31:20] == rv_exec_pkg::MRET) begin
                    wr = 1'b1;
                    nxt = model_mepc;
                end else begin
                    exc = rv_exec_pkg::EXC_ILLEGAL;
                end
            end
            default: exc = rv_exec_pkg::EXC_ILLEGAL;
        endcase
        if (exc != rv_exec_pkg::EXC_NONE) begin
            nxt = rv_exec_pkg::TRAP_VECTOR;
            wr = 1'b0;
            model_mepc = p;
        end
        wr = wr && w[11:7] != 5'd0;
        if (wr) model_regs[w[11:7]] = res;
        e.check_data = wr || mem;
        e.r = '{valid: 1'b1, pc: p, next_pc: nxt, rd_we: wr, rd_addr: w[11:7],
                rd_data: res, exc: exc};
        return e;
    endfunction

    task automatic drive_cycle(input logic want);
        logic [31:0] w;
        logic [31:0] p;
        exp_t        e;
        w = rand_inst();
        p = $urandom;
        p[1:0] = 2'b00;
        e = '0;
        if (want) e = model_exec(w, p);
        inst_valid = want;
        inst = w;
        pc = p;
        exp_q.push_back(e);
    endtask

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expv, actv);
        end
    endtask

    // Entry pushed before edge N is compared at edge N+2
    always @(posedge clk) begin : check_retire
        exp_t e;
        if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            if (e.r.valid && !retire.valid) begin
                errors++;
                $display("Error: no retire for the instruction at pc %h", e.r.pc);
            end else if (!e.r.valid && retire.valid) begin
                errors++;
                $display("Error: retire.valid set after an idle cycle, pc %h", retire.pc);
            end else if (e.r.valid) begin
                check_field("retire.pc", e.r.pc, retire.pc);
                check_field("retire.next_pc", e.r.next_pc, retire.next_pc);
                check_field("retire.rd_we", 32'(e.r.rd_we), 32'(retire.rd_we));
                check_field("retire.rd_addr", 32'(e.r.rd_addr), 32'(retire.rd_addr));
                check_field("retire.exc", 32'(e.r.exc), 32'(retire.exc));
                if (e.check_data) check_field("retire.rd_data", e.r.rd_data, retire.rd_data);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog timeout after %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        model_mepc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_cycle($urandom_range(0, 9) < 8);
            @(negedge clk);
        end
        // Flush the last instruction through retire
        repeat (2) begin
            drive_cycle(1'b0);
            @(negedge clk);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/rv_exec_pkg.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/operand_stage.sv
rtl/execute_stage.sv
rtl/rv_exec_top.sv
dv/rv_exec_sva.sv
dv/tb_rv_exec.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_exec_pkg::xlen_t   a,
    input  wire rv_exec_pkg::xlen_t   b,
    input  wire rv_exec_pkg::alu_op_t op,
    output rv_exec_pkg::xlen_t        y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_exec_pkg::ADD:  y = a + b;
            rv_exec_pkg::SUB:  y = a - b;
            rv_exec_pkg::SLL:  y = a << shamt;
            rv_exec_pkg::SLT:  y = {31'b0, $signed(a) < $signed(b)};
            rv_exec_pkg::SLTU: y = {31'b0, a < b};
            rv_exec_pkg::XOR:  y = a ^ b;
            rv_exec_pkg::SRL:  y = a >> shamt;
            rv_exec_pkg::SRA:  y = rv_exec_pkg::xlen_t'($signed(a) >>> shamt);
            rv_exec_pkg::OR:   y = a | b;
            rv_exec_pkg::AND:  y = a & b;
            // Unused funct7 combinations
            default:           y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire rv_exec_pkg::inst_t  inst,
    input  wire                      take_branch,
    input  wire                      trap_start,
    input  wire                      trap_finish,
    input  wire rv_exec_pkg::xlen_t  alu_out,
    output rv_exec_pkg::immed_type_t immed_type,
    output rv_exec_pkg::alu_a_src_t  alu_a_src,
    output rv_exec_pkg::alu_b_src_t  alu_b_src,
    output rv_exec_pkg::alu_op_t     alu_op,
    output rv_exec_pkg::reg_src_t    reg_src,
    output rv_exec_pkg::pc_src_t     pc_src,
    output logic                     illegal_inst,
    output logic                     inst_addr_misalign,
    output logic                     load_addr_misalign,
    output logic                     store_addr_misalign,
    output logic                     env_call,
    output logic                     env_break
);

    rv_exec_pkg::opcode_t opcode;
    logic [2:0]           funct3;
    logic                 funct7_b5;

    assign opcode    = rv_exec_pkg::opcode_t'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];

    always_comb begin
        unique case (opcode)
            rv_exec_pkg::LUI, rv_exec_pkg::AUIPC: immed_type = rv_exec_pkg::U_IMMED;
            rv_exec_pkg::JAL:    immed_type = rv_exec_pkg::J_IMMED;
            rv_exec_pkg::BRANCH: immed_type = rv_exec_pkg::B_IMMED;
            rv_exec_pkg::STORE:  immed_type = rv_exec_pkg::S_IMMED;
            default:             immed_type = rv_exec_pkg::I_IMMED;
        endcase
    end

    // Operand selects
    always_comb begin
        alu_a_src = rv_exec_pkg::RS1;
        alu_b_src = rv_exec_pkg::IMMED;
        unique case (opcode)
            rv_exec_pkg::LUI: alu_a_src = rv_exec_pkg::ZERO;
            rv_exec_pkg::AUIPC, rv_exec_pkg::JAL, rv_exec_pkg::BRANCH:
                alu_a_src = rv_exec_pkg::CURR_PC;
            rv_exec_pkg::OP: alu_b_src = rv_exec_pkg::RS2;
            default: ;
        endcase
    end

    always_comb begin
        unique case (opcode)
            rv_exec_pkg::JAL, rv_exec_pkg::JALR:   reg_src = rv_exec_pkg::NEXT_PC;
            rv_exec_pkg::LOAD, rv_exec_pkg::STORE: reg_src = rv_exec_pkg::MEM;
            rv_exec_pkg::SYSTEM:                   reg_src = rv_exec_pkg::CSR;
            default:                               reg_src = rv_exec_pkg::ALU;
        endcase
    end

    // Traps override the opcode
    always_comb begin
        if (trap_start) begin
            pc_src = rv_exec_pkg::CSR_MTVEC;
        end else if (trap_finish) begin
            pc_src = rv_exec_pkg::CSR_MEPC;
        end else begin
            unique case (opcode)
                rv_exec_pkg::JAL:    pc_src = rv_exec_pkg::ALU_OUT;
                rv_exec_pkg::JALR:   pc_src = rv_exec_pkg::LSB_ZERO;
                rv_exec_pkg::BRANCH:
                    pc_src = take_branch ? rv_exec_pkg::ALU_OUT : rv_exec_pkg::PC_PLUS_4;
                default:             pc_src = rv_exec_pkg::PC_PLUS_4;
            endcase
        end
    end

    always_comb begin
        unique case (opcode)
            rv_exec_pkg::OP: alu_op = rv_exec_pkg::alu_op_t'({funct7_b5, funct3});
            // Only SRAI carries funct7[5]
            rv_exec_pkg::OP_IMM:
                alu_op = rv_exec_pkg::alu_op_t'({funct3 == rv_exec_pkg::FUNCT3_SR && funct7_b5,
                                                 funct3});
            default: alu_op = rv_exec_pkg::ADD;
        endcase
    end

    always_comb begin
        illegal_inst        = 1'b0;
        inst_addr_misalign  = 1'b0;
        load_addr_misalign  = 1'b0;
        store_addr_misalign = 1'b0;
        env_call            = 1'b0;
        env_break           = 1'b0;
        unique case (opcode)
            rv_exec_pkg::LUI, rv_exec_pkg::AUIPC, rv_exec_pkg::OP_IMM, rv_exec_pkg::OP,
            rv_exec_pkg::FENCE: ;
            rv_exec_pkg::JAL:    inst_addr_misalign = alu_out[1:0] != 2'b00;
            rv_exec_pkg::JALR:   inst_addr_misalign = alu_out[1];
            rv_exec_pkg::BRANCH: inst_addr_misalign = take_branch && alu_out[1:0] != 2'b00;
            rv_exec_pkg::LOAD: begin
                if (inst[13:12] == rv_exec_pkg::WORD) load_addr_misalign = |alu_out[1:0];
                if (inst[13:12] == rv_exec_pkg::HALF) load_addr_misalign = alu_out[0];
            end
            rv_exec_pkg::STORE: begin
                if (inst[13:12] == rv_exec_pkg::WORD) store_addr_misalign = |alu_out[1:0];
                if (inst[13:12] == rv_exec_pkg::HALF) store_addr_misalign = alu_out[0];
            end
            rv_exec_pkg::SYSTEM: begin
                // Nonzero funct3 is a CSR access
                if (funct3 == 3'b000) begin
                    case (inst[31:20])
                        rv_exec_pkg::MRET:   ;
                        rv_exec_pkg::ECALL:  env_call = 1'b1;
                        rv_exec_pkg::EBREAK: env_break = 1'b1;
                        default:             illegal_inst = 1'b1;
                    endcase
                end
            end
            default: illegal_inst = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rv_exec_pkg::op_stage_t op,
    output rv_exec_pkg::wb_t            wb,
    output rv_exec_pkg::retire_t        retire
);

    rv_exec_pkg::opcode_t     opcode;
    logic [2:0]               funct3;
    rv_exec_pkg::immed_type_t immed_type;
    rv_exec_pkg::alu_a_src_t  alu_a_src;
    rv_exec_pkg::alu_b_src_t  alu_b_src;
    rv_exec_pkg::alu_op_t     alu_op;
    rv_exec_pkg::reg_src_t    reg_src;
    rv_exec_pkg::pc_src_t     pc_src;
    logic                     illegal_inst;
    logic                     inst_addr_misalign;
    logic                     load_addr_misalign;
    logic                     store_addr_misalign;
    logic                     env_call;
    logic                     env_break;
    logic                     take_branch;
    logic                     trap_start;
    logic                     trap_finish;
    logic                     writes_rd;
    rv_exec_pkg::xlen_t       imm;
    rv_exec_pkg::xlen_t       alu_a;
    rv_exec_pkg::xlen_t       alu_b;
    rv_exec_pkg::xlen_t       alu_y;
    rv_exec_pkg::xlen_t       pc_plus_4;
    rv_exec_pkg::xlen_t       next_pc;
    rv_exec_pkg::xlen_t       rd_data;
    rv_exec_pkg::xlen_t       mepc;
    rv_exec_pkg::exc_t        exc;

    assign opcode    = rv_exec_pkg::opcode_t'(op.inst[6:0]);
    assign funct3    = op.inst[14:12];
    assign pc_plus_4 = op.pc + 32'd4;

    decoder u_decoder (
        .inst                (op.inst),
        .take_branch         (take_branch),
        .trap_start          (trap_start),
        .trap_finish         (trap_finish),
        .alu_out             (alu_y),
        .immed_type          (immed_type),
        .alu_a_src           (alu_a_src),
        .alu_b_src           (alu_b_src),
        .alu_op              (alu_op),
        .reg_src             (reg_src),
        .pc_src              (pc_src),
        .illegal_inst        (illegal_inst),
        .inst_addr_misalign  (inst_addr_misalign),
        .load_addr_misalign  (load_addr_misalign),
        .store_addr_misalign (store_addr_misalign),
        .env_call            (env_call),
        .env_break           (env_break)
    );

    always_comb begin
        case (immed_type)
            rv_exec_pkg::S_IMMED: imm = {{20{op.inst[31]}}, op.inst[31:25], op.inst[11:7]};
            rv_exec_pkg::B_IMMED: imm = {{19{op.inst[31]}}, op.inst[31], op.inst[7],
                                         op.inst[30:25], op.inst[11:8], 1'b0};
            rv_exec_pkg::U_IMMED: imm = {op.inst[31:12], 12'b0};
            rv_exec_pkg::J_IMMED: imm = {{11{op.inst[31]}}, op.inst[31], op.inst[19:12],
                                         op.inst[20], op.inst[30:21], 1'b0};
            default:              imm = {{20{op.inst[31]}}, op.inst[31:20]};
        endcase
    end

    assign alu_a = (alu_a_src == rv_exec_pkg::CURR_PC) ? op.pc :
                   (alu_a_src == rv_exec_pkg::ZERO)    ? '0 : op.rs1_val;
    assign alu_b = (alu_b_src == rv_exec_pkg::IMMED) ? imm : op.rs2_val;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (alu_op),
        .y  (alu_y)
    );

    always_comb begin
        case (funct3)
            3'b000:  take_branch = op.rs1_val == op.rs2_val;
            3'b001:  take_branch = op.rs1_val != op.rs2_val;
            3'b100:  take_branch = $signed(op.rs1_val) < $signed(op.rs2_val);
            3'b101:  take_branch = $signed(op.rs1_val) >= $signed(op.rs2_val);
            3'b110:  take_branch = op.rs1_val < op.rs2_val;
            3'b111:  take_branch = op.rs1_val >= op.rs2_val;
            default: take_branch = 1'b0;
        endcase
    end

    assign trap_start  = illegal_inst | inst_addr_misalign | load_addr_misalign |
                         store_addr_misalign | env_call | env_break;
    assign trap_finish = opcode == rv_exec_pkg::SYSTEM && funct3 == 3'b000 &&
                         op.inst[31:20] == rv_exec_pkg::MRET;

    always_comb begin
        if (illegal_inst)             exc = rv_exec_pkg::EXC_ILLEGAL;
        else if (inst_addr_misalign)  exc = rv_exec_pkg::EXC_INST_MISALIGN;
        else if (load_addr_misalign)  exc = rv_exec_pkg::EXC_LOAD_MISALIGN;
        else if (store_addr_misalign) exc = rv_exec_pkg::EXC_STORE_MISALIGN;
        else if (env_call)            exc = rv_exec_pkg::EXC_ECALL;
        else if (env_break)           exc = rv_exec_pkg::EXC_EBREAK;
        else                          exc = rv_exec_pkg::EXC_NONE;
    end

    // Branches, stores, loads and FENCE leave rd alone
    always_comb begin
        case (opcode)
            rv_exec_pkg::LUI, rv_exec_pkg::AUIPC, rv_exec_pkg::JAL, rv_exec_pkg::JALR,
            rv_exec_pkg::OP_IMM, rv_exec_pkg::OP, rv_exec_pkg::SYSTEM: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        case (reg_src)
            rv_exec_pkg::NEXT_PC: rd_data = pc_plus_4;
            rv_exec_pkg::CSR:     rd_data = '0;
            default:              rd_data = alu_y;
        endcase
    end

    always_comb begin
        case (pc_src)
            rv_exec_pkg::ALU_OUT:   next_pc = alu_y;
            rv_exec_pkg::LSB_ZERO:  next_pc = {alu_y[31:1], 1'b0};
            rv_exec_pkg::CSR_MTVEC: next_pc = rv_exec_pkg::TRAP_VECTOR;
            rv_exec_pkg::CSR_MEPC:  next_pc = mepc;
            default:                next_pc = pc_plus_4;
        endcase
    end

    assign wb = '{we:   op.valid && writes_rd && !trap_start && op.inst[11:7] != '0,
                  addr: op.inst[11:7],
                  data: rd_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            retire <= '0;
        end else begin
            if (op.valid && trap_start) begin
                mepc <= op.pc;
            end
            retire <= '{valid: op.valid, pc: op.pc, next_pc: next_pc, rd_we: wb.we,
                        rd_addr: op.inst[11:7], rd_data: rd_data, exc: exc};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         inst_valid,
    input  wire rv_exec_pkg::inst_t     inst,
    input  wire rv_exec_pkg::xlen_t     pc,
    input  wire rv_exec_pkg::xlen_t     rs1_data,
    input  wire rv_exec_pkg::xlen_t     rs2_data,
    input  wire rv_exec_pkg::wb_t       wb,
    output rv_exec_pkg::reg_addr_t      rs1_addr,
    output rv_exec_pkg::reg_addr_t      rs2_addr,
    output rv_exec_pkg::op_stage_t      op
);

    rv_exec_pkg::xlen_t rs1_val;
    rv_exec_pkg::xlen_t rs2_val;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // Bypass from the instruction in execute
    assign rs1_val = (wb.we && wb.addr == rs1_addr) ? wb.data : rs1_data;
    assign rs2_val = (wb.we && wb.addr == rs2_addr) ? wb.data : rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op <= '0;
        end else if (inst_valid) begin
            op <= '{valid: 1'b1, pc: pc, inst: inst, rs1_val: rs1_val, rs2_val: rs2_val};
        end else begin
            op.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rv_exec_pkg::reg_addr_t rs1_addr,
    input  wire rv_exec_pkg::reg_addr_t rs2_addr,
    input  wire rv_exec_pkg::wb_t       wb,
    output rv_exec_pkg::xlen_t          rs1_data,
    output rv_exec_pkg::xlen_t          rs2_data
);

    rv_exec_pkg::xlen_t regs [rv_exec_pkg::NUM_REGS];

    // x0 stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== rtl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int NUM_REGS = 32;

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {I_IMMED, S_IMMED, B_IMMED, U_IMMED, J_IMMED} immed_type_t;
    typedef enum logic [1:0] {RS1, CURR_PC, ZERO} alu_a_src_t;
    typedef enum logic {RS2, IMMED} alu_b_src_t;
    typedef enum logic [1:0] {ALU, NEXT_PC, MEM, CSR} reg_src_t;
    typedef enum logic [2:0] {PC_PLUS_4, ALU_OUT, LSB_ZERO, CSR_MTVEC, CSR_MEPC} pc_src_t;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_t;

    localparam logic [2:0] FUNCT3_SR = 3'b101;

    // Access size in funct3[1:0]
    localparam logic [1:0] WORD = 2'b10;
    localparam logic [1:0] HALF = 2'b01;

    localparam logic [11:0] ECALL  = 12'h000;
    localparam logic [11:0] EBREAK = 12'h001;
    localparam logic [11:0] MRET   = 12'h302;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ILLEGAL,
        EXC_INST_MISALIGN,
        EXC_LOAD_MISALIGN,
        EXC_STORE_MISALIGN,
        EXC_ECALL,
        EXC_EBREAK
    } exc_t;

    localparam xlen_t TRAP_VECTOR = 32'h0000_0040;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
        xlen_t rs1_val;
        xlen_t rs2_val;
    } op_stage_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     next_pc;
        logic      rd_we;
        reg_addr_t rd_addr;
        xlen_t     rd_data;
        exc_t      exc;
    } retire_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/rv_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     inst_valid,
    input  wire rv_exec_pkg::inst_t inst,
    input  wire rv_exec_pkg::xlen_t pc,
    output rv_exec_pkg::retire_t    retire
);

    rv_exec_pkg::reg_addr_t rs1_addr;
    rv_exec_pkg::reg_addr_t rs2_addr;
    rv_exec_pkg::xlen_t     rs1_data;
    rv_exec_pkg::xlen_t     rs2_data;
    rv_exec_pkg::op_stage_t op;
    rv_exec_pkg::wb_t       wb;

    operand_stage u_operand_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb         (wb),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .op         (op)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (op),
        .wb     (wb),
        .retire (retire)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_exec -f filelist.f -o sim_rv_exec
./obj_dir/sim_rv_exec | tee sim.log
if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
